//--- hdl/pf_params.svh
`ifndef PF_PARAMS_SVH
`define PF_PARAMS_SVH

// address width of the processor in bits.
`define PF_ADDR_W 16

// one cache line holds eight 16-bit words.
`define PF_LINE_W 128

// byte stride from one line to the next sequential line.
`define PF_LINE_BYTES 16

`endif

//--- hdl/lc3b_pkg.sv
`default_nettype none

`include "pf_params.svh"

package lc3b_pkg;

    // a byte address on the processor side.
    typedef logic [`PF_ADDR_W-1:0] word_t;

    // one full cache line as it moves between the caches.
    typedef logic [`PF_LINE_W-1:0] line_t;

endpackage : lc3b_pkg

`default_nettype wire

//--- hdl/pf_bus_pkg.sv
`default_nettype none

package pf_bus_pkg;

    typedef struct packed {
        logic              read;   // held high until resp is seen.
        lc3b_pkg::word_t   addr;   // line-aligned address.
    } icache_req_t;

    typedef struct packed {
        logic              resp;   // one-cycle pulse, rdata valid.
        lc3b_pkg::line_t   rdata;
    } icache_rsp_t;

    typedef struct packed {
        logic              read;
        lc3b_pkg::word_t   addr;
    } l2_req_t;

    typedef struct packed {
        logic              resp;
        lc3b_pkg::line_t   rdata;
    } l2_rsp_t;

    // strobes and mux selects from the FSM to the datapath
    typedef struct packed {
        logic load_pf_addr;        // capture the next-line address, clears valid.
        logic load_pf_line;        // capture the L2 line, sets valid.
        logic rdata_sel;           // 1 selects the buffered line for the I-cache.
        logic l2_addr_sel;         // 1 selects the prefetch address for L2.
    } pf_ctrl_t;

endpackage : pf_bus_pkg

`default_nettype wire

//--- hdl/pf_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pf_controller (
    input  wire                     clk,
    input  wire                     i_arst_n,

    input  wire pf_bus_pkg::icache_req_t i_icache,
    input  wire                     i_l2_resp,

    input  wire lc3b_pkg::word_t    i_pf_addr,
    input  wire                     i_pf_valid,

    output pf_bus_pkg::pf_ctrl_t    o_ctrl,
    output logic                    o_icache_resp,
    output logic                    o_l2_read
);

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_FETCH    = 2'd1,
        ST_PREFETCH = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    logic addr_match;
    logic hit;

    assign addr_match = (i_pf_addr == i_icache.addr);
    assign hit        = i_icache.read & i_pf_valid & addr_match;

    // Mealy outputs, the hit answers in the request cycle.
    always_comb begin
        o_ctrl        = '0;
        o_icache_resp = 1'b0;
        o_l2_read     = 1'b0;

        case (state)
            ST_IDLE: begin
                if (hit) begin
                    o_ctrl.rdata_sel = 1'b1;
                    o_icache_resp    = 1'b1;
                end
            end
            ST_FETCH: begin
                o_ctrl.load_pf_addr = 1'b1;  // tracks the address the I-cache holds.
                o_l2_read           = 1'b1;
                o_icache_resp       = i_l2_resp;  // demand line passes straight through.
            end
            ST_PREFETCH: begin
                o_ctrl.l2_addr_sel  = 1'b1;
                o_l2_read           = 1'b1;
                o_ctrl.load_pf_line = i_l2_resp;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_nxt = state;

        case (state)
            ST_IDLE: begin
                if (i_icache.read && !hit) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (i_l2_resp) begin
                    state_nxt = ST_PREFETCH;
                end
            end
            ST_PREFETCH: begin
                // a pending read that misses the new line goes straight to L2.
                if (i_l2_resp) begin
                    if (!i_icache.read || addr_match) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        state_nxt = ST_FETCH;
                    end
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule : pf_controller

`default_nettype wire

//--- hdl/pf_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "pf_params.svh"

module pf_datapath (
    input  wire                     clk,
    input  wire                     i_arst_n,

    input  wire pf_bus_pkg::pf_ctrl_t i_ctrl,
    input  wire lc3b_pkg::word_t    i_icache_addr,
    input  wire lc3b_pkg::line_t    i_l2_rdata,

    output lc3b_pkg::word_t         o_pf_addr,
    output logic                    o_pf_valid,
    output lc3b_pkg::line_t         o_icache_rdata,
    output lc3b_pkg::word_t         o_l2_addr
);

    lc3b_pkg::word_t next_line_addr;
    lc3b_pkg::word_t pf_addr_q;
    lc3b_pkg::line_t pf_line_q;
    logic            pf_valid_q;

    // the address wraps at the top of memory like the processor PC does.
    assign next_line_addr = i_icache_addr + lc3b_pkg::word_t'(`PF_LINE_BYTES);

    always_ff @(posedge clk) begin
        if (i_ctrl.load_pf_addr) begin
            pf_addr_q <= next_line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ctrl.load_pf_line) begin
            pf_line_q <= i_l2_rdata;
        end
    end

    // a new target address makes the old buffer content stale.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pf_valid_q <= 1'b0;
        end else if (i_ctrl.load_pf_addr) begin
            pf_valid_q <= 1'b0;
        end else if (i_ctrl.load_pf_line) begin
            pf_valid_q <= 1'b1;
        end
    end

    always_comb begin
        if (i_ctrl.rdata_sel) begin
            o_icache_rdata = pf_line_q;
        end else begin
            o_icache_rdata = i_l2_rdata;
        end
    end

    always_comb begin
        if (i_ctrl.l2_addr_sel) begin
            o_l2_addr = pf_addr_q;
        end else begin
            o_l2_addr = i_icache_addr;
        end
    end

    assign o_pf_addr  = pf_addr_q;
    assign o_pf_valid = pf_valid_q;

endmodule : pf_datapath

`default_nettype wire

//--- hdl/line_prefetcher.sv
`timescale 1ns/1ps
`default_nettype none

module line_prefetcher (
    input  wire                          clk,
    input  wire                          i_arst_n,

    input  wire pf_bus_pkg::icache_req_t i_icache,
    output wire pf_bus_pkg::icache_rsp_t o_icache,

    output wire pf_bus_pkg::l2_req_t     o_l2,
    input  wire pf_bus_pkg::l2_rsp_t     i_l2
);

    wire pf_bus_pkg::pf_ctrl_t ctrl;
    wire lc3b_pkg::word_t      pf_addr;
    wire                       pf_valid;

    pf_controller u_pf_controller (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_icache      (i_icache),
        .i_l2_resp     (i_l2.resp),
        .i_pf_addr     (pf_addr),
        .i_pf_valid    (pf_valid),
        .o_ctrl        (ctrl),
        .o_icache_resp (o_icache.resp),
        .o_l2_read     (o_l2.read)
    );

    pf_datapath u_pf_datapath (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_ctrl         (ctrl),
        .i_icache_addr  (i_icache.addr),
        .i_l2_rdata     (i_l2.rdata),
        .o_pf_addr      (pf_addr),
        .o_pf_valid     (pf_valid),
        .o_icache_rdata (o_icache.rdata),
        .o_l2_addr      (o_l2.addr)
    );

endmodule : line_prefetcher

`default_nettype wire

//--- verif/line_prefetcher_chk.sv
`timescale 1ns/1ps
`default_nettype none

module line_prefetcher_chk (
    input  wire                          clk,
    input  wire                          i_arst_n,
    input  wire pf_bus_pkg::icache_req_t i_icache_req,
    input  wire pf_bus_pkg::icache_rsp_t i_icache_rsp,
    input  wire pf_bus_pkg::l2_req_t     i_l2_req,
    input  wire pf_bus_pkg::l2_rsp_t     i_l2_rsp
);

    int unsigned err_count = 0;

    // an L2 read keeps its address until the line comes back.
    l2_addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_l2_req.read && !i_l2_rsp.resp) |=> (i_l2_req.read && $stable(i_l2_req.addr)))
        else begin
            err_count++;
            $error("L2 read dropped or its address changed before the response");
        end

    resp_needs_read: assert property (@(posedge clk)
        i_icache_rsp.resp |-> i_icache_req.read)
        else begin
            err_count++;
            $error("I-cache response without a pending read");
        end

    reset_quiet: assert property (@(posedge clk)
        $rose(i_arst_n) |-> (!i_icache_rsp.resp && !i_l2_req.read))
        else begin
            err_count++;
            $error("I-cache resp or L2 read high right after reset");
        end

endmodule : line_prefetcher_chk

`default_nettype wire

//--- verif/line_prefetcher_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pf_params.svh"

module line_prefetcher_tb;

    localparam logic [31:0] LFSR_SEED    = 32'h4135_31c0;
    localparam int          NUM_READS    = 400;
    localparam int          RESP_TIMEOUT = 40;

    logic                    clk;
    logic                    i_arst_n;
    pf_bus_pkg::icache_req_t i_icache;
    pf_bus_pkg::icache_rsp_t o_icache;
    pf_bus_pkg::l2_req_t     o_l2;
    pf_bus_pkg::l2_rsp_t     i_l2;

    logic [31:0]     stim_lfsr  = LFSR_SEED;
    logic [31:0]     l2_lfsr    = LFSR_SEED;
    logic            l2_active  = 1'b0;
    logic            l2_is_pf   = 1'b0;
    logic            expect_pf  = 1'b0;
    logic            buf_valid  = 1'b0;
    lc3b_pkg::word_t pf_target  = '0;
    lc3b_pkg::word_t buf_addr   = '0;
    int              hit_count  = 0;
    int              miss_count = 0;

    line_prefetcher u_line_prefetcher (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_icache (i_icache),
        .o_icache (o_icache),
        .o_l2     (o_l2),
        .i_l2     (i_l2)
    );

    bind line_prefetcher line_prefetcher_chk u_chk (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_icache_req (i_icache),
        .i_icache_rsp (o_icache),
        .i_l2_req     (o_l2),
        .i_l2_rsp     (i_l2)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[14:0], st[0]};
        end
    endtask

    // every word mixes both address bytes so neighbouring lines differ everywhere.
    function automatic lc3b_pkg::line_t line_ref(input lc3b_pkg::word_t addr);
        lc3b_pkg::line_t line;
        int w;
        for (w = 0; w < `PF_LINE_W / `PF_ADDR_W; w++) begin
            line[w*`PF_ADDR_W +: `PF_ADDR_W] = {addr[7:0], addr[15:8]} ^ (addr + 16'(w)) ^ 16'h3c5a;
        end
        return line;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic issue_read(input lc3b_pkg::word_t addr, input int gap);
        int cycles;
        int i;
        for (i = 0; i < gap; i++) begin
            @(posedge clk);
            i_icache <= '0;
        end
        @(posedge clk);
        i_icache <= '{read: 1'b1, addr: addr};
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (cycles <= RESP_TIMEOUT) else
                stop_run($sformatf("no I-cache response for address %h within %0d cycles",
                                   addr, RESP_TIMEOUT));
        end while (!o_icache.resp);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin : l2_model
        logic [15:0]     lat_bits;
        lc3b_pkg::word_t req_addr;
        int              lat;
        i_l2 = '0;
        forever begin
            @(negedge clk);
            if (i_arst_n && o_l2.read) begin
                req_addr = o_l2.addr;
                take_bits(l2_lfsr, 3, lat_bits);
                lat = 1 + (lat_bits % 6);
                repeat (lat) @(posedge clk);
                i_l2 <= '{resp: 1'b1, rdata: line_ref(req_addr)};
                @(posedge clk);
                i_l2 <= '0;
            end
        end
    end

    always @(negedge clk) begin : compare
        logic exp_hit;
        logic demand_done;
        if (i_arst_n) begin
            exp_hit     = i_icache.read && buf_valid && !l2_active && (i_icache.addr == buf_addr);
            demand_done = l2_active && i_l2.resp && !l2_is_pf;
            assert (o_icache.resp == (exp_hit || demand_done)) else
                stop_run($sformatf("FAIL %0t: I-cache resp %0b for address %h, expected %0b",
                                   $time, o_icache.resp, i_icache.addr, exp_hit || demand_done));
            if (o_icache.resp) begin
                assert (o_icache.rdata == line_ref(i_icache.addr)) else
                    stop_run($sformatf("FAIL %0t: wrong line for address %h", $time,
                                       i_icache.addr));
                if (exp_hit) begin
                    hit_count++;
                end else begin
                    miss_count++;
                end
            end
            if (exp_hit) begin
                assert (!o_l2.read) else
                    stop_run($sformatf("FAIL %0t: L2 read for buffered address %h", $time,
                                       i_icache.addr));
            end
            if (l2_active) begin
                if (i_l2.resp) begin
                    l2_active = 1'b0;
                    if (l2_is_pf) begin
                        buf_addr  = pf_target;  // the prefetched line is now usable.
                        buf_valid = 1'b1;
                    end else begin
                        expect_pf = 1'b1;
                        pf_target = i_icache.addr + lc3b_pkg::word_t'(`PF_LINE_BYTES);
                    end
                end
            end else if (o_l2.read) begin
                l2_active = 1'b1;
                l2_is_pf  = expect_pf;
                if (expect_pf) begin
                    assert (o_l2.addr == pf_target) else
                        stop_run($sformatf("FAIL %0t: prefetch address %h, expected %h",
                                           $time, o_l2.addr, pf_target));
                    expect_pf = 1'b0;
                end else begin
                    assert (i_icache.read && o_l2.addr == i_icache.addr) else
                        stop_run($sformatf("FAIL %0t: demand address %h, requested %h",
                                           $time, o_l2.addr, i_icache.addr));
                    buf_valid = 1'b0;
                end
            end
            assert (u_line_prefetcher.u_chk.err_count == 0) else
                stop_run("the bound protocol checker flagged an assertion failure");
        end
    end

    initial begin : stimulus
        lc3b_pkg::word_t addr;
        logic [15:0]     bits;
        int              gap;
        int              n;
        i_arst_n = 1'b0;
        i_icache = '0;
        repeat (8) @(posedge clk);
        i_arst_n <= 1'b1;
        for (n = 0; n < 4; n++) begin
            @(negedge clk);
            assert (!o_icache.resp && !o_l2.read) else
                stop_run($sformatf("FAIL %0t: resp or L2 read high with no request", $time));
        end
        addr = '0;
        for (n = 0; n < NUM_READS; n++) begin
            take_bits(stim_lfsr, 2, bits);
            if (bits[1] == 1'b0) begin
                addr = addr + lc3b_pkg::word_t'(`PF_LINE_BYTES);  // next sequential line.
            end else if (bits[0] == 1'b1) begin
                take_bits(stim_lfsr, 16, bits);
                addr = bits & ~lc3b_pkg::word_t'(`PF_LINE_BYTES - 1);
            end
            take_bits(stim_lfsr, 2, bits);
            gap = bits[1:0];
            issue_read(addr, gap);
        end
        @(posedge clk);
        i_icache <= '0;
        $display("reads %0d, buffer hits %0d, misses %0d", NUM_READS, hit_count, miss_count);
        if (hit_count > 0 && miss_count > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("the run did not exercise both buffer hits and misses");
        end
    end

endmodule : line_prefetcher_tb

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/lc3b_pkg.sv
hdl/pf_bus_pkg.sv
hdl/pf_controller.sv
hdl/pf_datapath.sv
hdl/line_prefetcher.sv
verif/line_prefetcher_chk.sv
verif/line_prefetcher_tb.sv

//--- Bender.yml
package:
  name: line_prefetcher

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc3b_pkg.sv
      - hdl/pf_bus_pkg.sv
      - hdl/pf_controller.sv
      - hdl/pf_datapath.sv
      - hdl/line_prefetcher.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/line_prefetcher_chk.sv
      - verif/line_prefetcher_tb.sv
